// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_camera_system
FILELIST   := camera_system.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the terminal, awk sets the exit status from the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: camera_system.f
+incdir+source
source/camera_pkg.sv
source/ov7670_capture.sv
source/frame_buffer.sv
source/vga_timing.sv
source/display_compose.sv
source/camera_system.sv
verif/tb_camera_system.sv

// File: source/camera_params.svh
`ifndef CAMERA_PARAMS_SVH
`define CAMERA_PARAMS_SVH

// Stored image per camera, RGB565 pixels
`define IMG_WIDTH   160
`define IMG_HEIGHT  120
`define FB_ADDR_W   15      // Enough for 19200 pixels

// 640x480 at 60 Hz, in pixels
`define H_VISIBLE   640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48

// Same, in lines
`define V_VISIBLE   480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33

`define PIX_DIV     4       // clk cycles per VGA pixel

`endif

// File: source/camera_pkg.sv
`include "camera_params.svh"

package camera_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;                          // Camera native format

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;                          // VGA DAC format

    // Raw pins of one OV7670-style camera
    typedef struct packed {
        logic [7:0] data;
        logic       href;
        logic       vsync;
        logic       pclk;
    } cam_pins_t;

    typedef struct packed {
        logic                  we;
        logic [`FB_ADDR_W-1:0] addr;
        rgb565_t               data;
    } fb_write_t;                        // One buffer write

    typedef struct packed {
        logic       de;
        logic       h_sync;              // Active low
        logic       v_sync;              // Active low
        logic [9:0] x;
        logic [9:0] y;
    } screen_pos_t;

    typedef struct packed {
        logic    h_sync;
        logic    v_sync;
        logic    de;
        rgb444_t rgb;
    } vga_pixel_t;

    typedef enum logic [1:0] {
        cap_wait_frame,                  // Until vsync falls
        cap_high_byte,
        cap_low_byte
    } cap_state_t;

    typedef enum logic [1:0] {
        region_blank,
        region_cam1,                     // Lower left
        region_cam2                      // Lower right
    } region_t;

endpackage

// File: source/camera_system.sv
`timescale 1ns/100ps
`include "camera_params.svh"

module camera_system (
    input  logic                   clk,
    input  logic                   rst_n,
    input  camera_pkg::cam_pins_t  cam1,     // Shown lower left
    input  camera_pkg::cam_pins_t  cam2,     // Shown lower right
    output camera_pkg::vga_pixel_t vga_out,
    output logic                   pix_stb
);
    import camera_pkg::*;

    fb_write_t             cam1_wr;
    fb_write_t             cam2_wr;
    logic [`FB_ADDR_W-1:0] rd_addr;          // Shared by both buffers
    rgb565_t               cam1_pix;
    rgb565_t               cam2_pix;
    logic                  scan_stb;         // Pixel enable from the timing block
    screen_pos_t           scan_pos;

    ov7670_capture u_cam1_capture (
        .clk   (clk),
        .rst_n (rst_n),
        .cam   (cam1),
        .fb_wr (cam1_wr)
    );

    ov7670_capture u_cam2_capture (
        .clk   (clk),
        .rst_n (rst_n),
        .cam   (cam2),
        .fb_wr (cam2_wr)
    );

    frame_buffer u_cam1_buffer (
        .clk     (clk),
        .wr      (cam1_wr),
        .rd_addr (rd_addr),
        .rd_data (cam1_pix)
    );

    frame_buffer u_cam2_buffer (
        .clk     (clk),
        .wr      (cam2_wr),
        .rd_addr (rd_addr),
        .rd_data (cam2_pix)
    );

    vga_timing u_vga_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_stb (scan_stb),
        .pos     (scan_pos)
    );

    display_compose u_display_compose (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_stb  (scan_stb),
        .pos      (scan_pos),
        .rd_addr  (rd_addr),
        .cam1_pix (cam1_pix),
        .cam2_pix (cam2_pix),
        .vga_out  (vga_out),
        .vga_stb  (pix_stb)
    );

endmodule

// File: source/display_compose.sv
`timescale 1ns/100ps
`include "camera_params.svh"

module display_compose (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_stb,
    input  camera_pkg::screen_pos_t pos,
    output logic [`FB_ADDR_W-1:0]   rd_addr,
    input  camera_pkg::rgb565_t     cam1_pix,
    input  camera_pkg::rgb565_t     cam2_pix,
    output camera_pkg::vga_pixel_t  vga_out,
    output logic                    vga_stb
);
    import camera_pkg::*;

    localparam logic [9:0] QUAD_W = 10'(2 * `IMG_WIDTH);   // 320, image doubled
    localparam logic [9:0] QUAD_H = 10'(2 * `IMG_HEIGHT);  // 240

    region_t               region;
    logic [9:0]            row_off;      // Lines into the lower half
    logic [9:0]            col_off;      // Pixels into the quadrant
    logic [8:0]            src_row;
    logic [8:0]            src_col;
    logic [`FB_ADDR_W-1:0] scan_addr;
    rgb565_t               src_pix;
    rgb444_t               out_rgb;

    always_comb begin
        if (!pos.de || pos.y < QUAD_H)
            region = region_blank;       // Upper half and blanking
        else if (pos.x < QUAD_W)
            region = region_cam1;
        else
            region = region_cam2;
    end

    // 2x scaling, drop the low bit of each offset
    assign row_off   = pos.y - QUAD_H;
    assign col_off   = (pos.x < QUAD_W) ? pos.x : pos.x - QUAD_W;
    assign src_row   = row_off[9:1];
    assign src_col   = col_off[9:1];
    assign scan_addr = `FB_ADDR_W'(src_row) * `FB_ADDR_W'(`IMG_WIDTH)
                     + `FB_ADDR_W'(src_col);

    assign rd_addr = (region == region_blank) ? '0 : scan_addr;  // Keep reads in range

    // Buffer data has settled by the next strobe
    always_comb begin
        case (region)
            region_cam1: src_pix = cam1_pix;
            region_cam2: src_pix = cam2_pix;
            default:     src_pix = '0;   // Black
        endcase
    end

    assign out_rgb = '{r: src_pix.r[4:1], g: src_pix.g[5:2], b: src_pix.b[4:1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_out <= '{h_sync: 1'b1, v_sync: 1'b1, de: 1'b0, rgb: '0};
            vga_stb <= 1'b0;
        end else begin
            vga_stb <= pix_stb;          // Marks first cycle of a new vga_out
            if (pix_stb)
                vga_out <= '{h_sync: pos.h_sync, v_sync: pos.v_sync, de: pos.de,
                             rgb: out_rgb};
        end
    end

endmodule

// File: source/frame_buffer.sv
`timescale 1ns/100ps
`include "camera_params.svh"

module frame_buffer (
    input  logic                  clk,
    input  camera_pkg::fb_write_t wr,
    input  logic [`FB_ADDR_W-1:0] rd_addr,
    output camera_pkg::rgb565_t   rd_data
);
    import camera_pkg::*;

    localparam int DEPTH = `IMG_WIDTH * `IMG_HEIGHT;

    rgb565_t mem [DEPTH];                // One full 160x120 frame

    // Capture side
    always_ff @(posedge clk) begin
        if (wr.we)
            mem[wr.addr] <= wr.data;
    end

    // Display side, data one clk after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/ov7670_capture.sv
`timescale 1ns/100ps
`include "camera_params.svh"

module ov7670_capture (
    input  logic                  clk,
    input  logic                  rst_n,
    input  camera_pkg::cam_pins_t cam,
    output camera_pkg::fb_write_t fb_wr
);
    import camera_pkg::*;

    localparam logic [`FB_ADDR_W-1:0] PIX_COUNT = `FB_ADDR_W'(`IMG_WIDTH * `IMG_HEIGHT);

    cam_pins_t             cam_meta;     // First sync stage
    cam_pins_t             cam_sync;     // Second stage, data rides along for alignment
    logic                  pclk_prev;
    logic                  vsync_prev;
    logic                  pclk_rise;    // Registered rising edge of camera pclk
    cap_state_t            state;
    logic [7:0]            high_byte;    // First half of the pixel
    logic [`FB_ADDR_W-1:0] wr_addr;      // Next free slot
    logic                  out_we;
    logic [`FB_ADDR_W-1:0] out_addr;
    rgb565_t               out_data;

    // Two-flop synchronizer and edge register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cam_meta   <= '0;
            cam_sync   <= '0;
            pclk_prev  <= 1'b0;
            vsync_prev <= 1'b0;
            pclk_rise  <= 1'b0;
        end else begin
            cam_meta   <= cam;
            cam_sync   <= cam_meta;
            pclk_prev  <= cam_sync.pclk;
            vsync_prev <= cam_sync.vsync;
            pclk_rise  <= cam_sync.pclk & ~pclk_prev;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= cap_wait_frame;
            wr_addr <= '0;
            out_we  <= 1'b0;
        end else begin
            out_we <= 1'b0;                          // One clk per pixel
            if (cam_sync.vsync) begin
                state   <= cap_wait_frame;           // New frame on the way
                wr_addr <= '0;
            end else if (state == cap_wait_frame) begin
                if (vsync_prev)                      // vsync just fell
                    state <= cap_high_byte;
            end else if (pclk_rise) begin
                if (!cam_sync.href) begin
                    state <= cap_high_byte;          // Line gap resets byte pairing
                end else if (state == cap_high_byte) begin
                    state <= cap_low_byte;
                end else begin
                    state <= cap_high_byte;
                    if (wr_addr < PIX_COUNT) begin   // Surplus pixels dropped
                        out_we  <= 1'b1;
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
            end
        end
    end

    // Byte pairing, RGB565 arrives high byte first
    always_ff @(posedge clk) begin
        if (pclk_rise && cam_sync.href && state == cap_high_byte)
            high_byte <= cam_sync.data;
        if (pclk_rise && cam_sync.href && state == cap_low_byte) begin
            out_addr <= wr_addr;
            out_data <= {high_byte, cam_sync.data};
        end
    end

    assign fb_wr = '{we: out_we, addr: out_addr, data: out_data};

endmodule

// File: source/vga_timing.sv
`timescale 1ns/100ps
`include "camera_params.svh"

module vga_timing (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    pix_stb,
    output camera_pkg::screen_pos_t pos
);

    localparam int               DIV_W    = $clog2(`PIX_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);

    localparam logic [9:0] H_VIS      = 10'(`H_VISIBLE);
    localparam logic [9:0] H_SYNC_BEG = 10'(`H_VISIBLE + `H_FRONT);           // 656
    localparam logic [9:0] H_SYNC_END = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC); // 752
    localparam logic [9:0] H_LAST     = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK - 1);
    localparam logic [9:0] V_VIS      = 10'(`V_VISIBLE);
    localparam logic [9:0] V_SYNC_BEG = 10'(`V_VISIBLE + `V_FRONT);
    localparam logic [9:0] V_SYNC_END = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);
    localparam logic [9:0] V_LAST     = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [9:0]       h_cnt;             // 0..799
    logic [9:0]       v_cnt;             // 0..524
    logic             h_sync_d;
    logic             v_sync_d;
    logic             de_d;

    // 25 MHz pixel enable from clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            pix_stb <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            pix_stb <= (div_cnt == DIV_LAST);
        end
    end

    assign h_sync_d = !(h_cnt >= H_SYNC_BEG && h_cnt < H_SYNC_END);
    assign v_sync_d = !(v_cnt >= V_SYNC_BEG && v_cnt < V_SYNC_END);
    assign de_d     = (h_cnt < H_VIS) && (v_cnt < V_VIS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            pos   <= '{de: 1'b0, h_sync: 1'b1, v_sync: 1'b1, x: '0, y: '0};
        end else if (pix_stb) begin
            pos <= '{de: de_d, h_sync: h_sync_d, v_sync: v_sync_d, x: h_cnt, y: v_cnt};
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // Frame wrap
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verif/tb_camera_system.sv
`timescale 1ns/100ps
`include "camera_params.svh"

// One OV7670-style camera that sends a single frame then a surplus line
module camera_model (
    input  logic                  clk,
    input  logic [15:0]           pix_word,    // Pattern for pix_addr
    output int                    pix_addr,
    output camera_pkg::cam_pins_t pins,
    output logic                  done
);

    // Surplus line reaches past the address wrap back into the image
    localparam int SURPLUS_PIX = (1 << `FB_ADDR_W) - `IMG_WIDTH * `IMG_HEIGHT + `IMG_WIDTH;

    // One pclk period of 8 clk with fields changing as pclk falls
    task automatic pclk_cycle(input logic [7:0] data, input logic href, input logic vsync);
        @(posedge clk);
        pins <= '{data: data, href: href, vsync: vsync, pclk: 1'b0};
        repeat (4) @(posedge clk);
        pins.pclk <= 1'b1;                       // Capture edge
        repeat (3) @(posedge clk);
    endtask

    task automatic send_pixel(input int a, input logic [15:0] flip);
        logic [15:0] word;
        pix_addr = a;
        #1;                                      // Pattern settles
        word = pix_word ^ flip;
        pclk_cycle(word[15:8], 1'b1, 1'b0);      // High byte first
        pclk_cycle(word[7:0], 1'b1, 1'b0);
    endtask

    initial begin
        pins     = '0;
        pix_addr = -1;
        done     = 1'b0;
        repeat (8) @(posedge clk);               // Clear of reset
        repeat (2) pclk_cycle(8'h00, 1'b0, 1'b1);
        repeat (3) pclk_cycle(8'h00, 1'b0, 1'b0);
        for (int row = 0; row < `IMG_HEIGHT; row++) begin
            for (int col = 0; col < `IMG_WIDTH; col++)
                send_pixel(row * `IMG_WIDTH + col, 16'h0000);
            repeat (4) pclk_cycle(8'h00, 1'b0, 1'b0);  // Line gap
        end
        // Inverted surplus pixels that the full buffer must drop
        for (int col = 0; col < SURPLUS_PIX; col++)
            send_pixel(col, 16'hffff);
        repeat (4) pclk_cycle(8'h00, 1'b0, 1'b0);
        done = 1'b1;
    end

endmodule

module tb_camera_system;
    import camera_pkg::*;

    localparam int H_TOTAL    = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
    localparam int V_TOTAL    = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;  // 525
    localparam int H_SYNC_BEG = `H_VISIBLE + `H_FRONT;
    localparam int V_SYNC_BEG = `V_VISIBLE + `V_FRONT;
    localparam vga_pixel_t IDLE_PIXEL = '{h_sync: 1'b1, v_sync: 1'b1, de: 1'b0, rgb: '0};

    logic        clk;
    logic        rst_n;
    cam_pins_t   cam1;
    cam_pins_t   cam2;
    vga_pixel_t  vga_out;
    logic        pix_stb;
    int          cam1_addr;
    int          cam2_addr;
    logic [15:0] cam1_word;
    logic [15:0] cam2_word;
    logic        cam1_done;
    logic        cam2_done;
    int          seed;
    logic [15:0] cam_key [2];                    // Per camera scramble

    camera_system dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cam1    (cam1),
        .cam2    (cam2),
        .vga_out (vga_out),
        .pix_stb (pix_stb)
    );

    camera_model u_cam1_model (
        .clk      (clk),
        .pix_word (cam1_word),
        .pix_addr (cam1_addr),
        .pins     (cam1),
        .done     (cam1_done)
    );

    camera_model u_cam2_model (
        .clk      (clk),
        .pix_word (cam2_word),
        .pix_addr (cam2_addr),
        .pins     (cam2),
        .done     (cam2_done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                        // 250 MHz system clock

    // Odd multiplier keeps every address distinct
    function automatic logic [15:0] pattern(input int cam, input int a);
        return cam_key[cam] ^ 16'(a * 40503);
    endfunction

    always_comb cam1_word = pattern(0, cam1_addr);
    always_comb cam2_word = pattern(1, cam2_addr);

    function automatic vga_pixel_t expected_pixel(input int x, input int y);
        vga_pixel_t  px;
        logic [15:0] word;
        int          cam;
        int          a;
        px.h_sync = !(x >= H_SYNC_BEG && x < H_SYNC_BEG + `H_SYNC);
        px.v_sync = !(y >= V_SYNC_BEG && y < V_SYNC_BEG + `V_SYNC);
        px.de     = (x < `H_VISIBLE) && (y < `V_VISIBLE);
        px.rgb    = '0;                          // Upper half and blanking
        if (px.de && y >= 2 * `IMG_HEIGHT) begin
            cam    = (x < 2 * `IMG_WIDTH) ? 0 : 1;
            a      = ((y - 2 * `IMG_HEIGHT) / 2) * `IMG_WIDTH + (x % (2 * `IMG_WIDTH)) / 2;
            word   = pattern(cam, a);
            px.rgb = '{r: word[15:12], g: word[10:7], b: word[4:1]};
        end
        return px;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic check_idle();
        check_value("vga_out", 32'(vga_out), 32'(IDLE_PIXEL));
        check_value("pix_stb", 32'(pix_stb), 32'd0);
    endtask

    // Step to the next strobe due every PIX_DIV clocks
    task automatic next_pixel();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * `PIX_DIV)
                fail_run("pix_stb stopped toggling");
        end while (!pix_stb);
        check_value("pix_stb period", cycles, `PIX_DIV);
    endtask

    initial begin
        int waited;
        int x;
        int y;
        int h_low;
        int de_cnt;
        int v_lines;
        int de_lines;
        seed       = 32'hcb15_86d0;
        cam_key[0] = 16'($random(seed));
        cam_key[1] = 16'($random(seed));
        rst_n      = 1'b0;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;                           // Fourth reset edge
        waited = 0;
        @(negedge clk);
        while (!pix_stb) begin
            check_idle();                        // Still idle after release
            waited++;
            if (waited > 4 * `PIX_DIV)
                fail_run("pix_stb never rose after reset");
            @(negedge clk);
        end
        waited = 0;
        while (vga_out.v_sync) begin
            next_pixel();
            waited++;
            if (waited > H_TOTAL * V_TOTAL)
                fail_run("vga_out never showed v_sync");
        end
        if (!(cam1_done && cam2_done))
            fail_run("camera stimulus still running when the checked frame began");
        x        = 0;                            // First v_sync low pixel
        y        = V_SYNC_BEG;
        h_low    = 0;
        de_cnt   = 0;
        v_lines  = 0;
        de_lines = 0;
        for (int n = 0; n < H_TOTAL * V_TOTAL; n++) begin
            check_value($sformatf("vga_out at x=%0d y=%0d", x, y), 32'(vga_out),
                        32'(expected_pixel(x, y)));
            if (!vga_out.h_sync)
                h_low++;
            if (vga_out.de)
                de_cnt++;
            if (x == 0 && !vga_out.v_sync)
                v_lines++;
            if (x == H_TOTAL - 1) begin          // Line totals
                check_value("h_sync low pixels per line", h_low, `H_SYNC);
                check_value("de pixels per line", de_cnt, (y < `V_VISIBLE) ? `H_VISIBLE : 0);
                if (de_cnt == `H_VISIBLE)
                    de_lines++;
                h_low  = 0;
                de_cnt = 0;
                x      = 0;
                y      = (y == V_TOTAL - 1) ? 0 : y + 1;
            end else begin
                x++;
            end
            if (n < H_TOTAL * V_TOTAL - 1)
                next_pixel();
        end
        check_value("v_sync low lines", v_lines, `V_SYNC);
        check_value("de lines", de_lines, `V_VISIBLE);
        $display("=== PASS ===");
        $finish;
    end

endmodule
